/* include/rs_macros.svh */
// Issue queue sizing macros: depth, dispatch and result-bus widths, unit counts, field widths
`ifndef RS_MACROS_SVH
`define RS_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Queue geometry
////////////////////////////////////////////////////////////////////////////
`define RS_ENTRIES        8   // Number of queue entries
`define RS_DISPATCH_WIDTH 2   // Dispatch slots per cycle
`define RS_CDB_WIDTH      2   // Result-bus lanes

// Execution units per type
`define RS_NUM_ALU        2
`define RS_NUM_MUL        1

////////////////////////////////////////////////////////////////////////////
// Field widths
////////////////////////////////////////////////////////////////////////////
`define RS_TAG_BITS       6   // Physical register tag
`define RS_VALUE_BITS     32  // Operand value
`define RS_ROB_BITS       5   // ROB index
`define RS_OP_BITS        4   // Operation code

`endif

/* src/rs_issue_pkg.sv */
// Issue side types: execution unit type enum and the packet sent to a unit
`include "rs_macros.svh"

package rs_issue_pkg;

    // Execution unit types
    typedef enum logic [0:0] {
        FU_ALU = 1'b0,
        FU_MUL = 1'b1
    } fu_type_e;

    // Packet handed to a unit at issue
    typedef struct packed {
        logic [`RS_OP_BITS-1:0]    op;
        logic [`RS_VALUE_BITS-1:0] value1;     // First operand value
        logic [`RS_VALUE_BITS-1:0] value2;     // Second operand value
        logic [`RS_TAG_BITS-1:0]   dest_tag;
        logic [`RS_ROB_BITS-1:0]   rob_entry;
    } issue_packet_t;

endpackage

/* src/rs_entry_pkg.sv */
// Queue entry types: operand union, operand with ready bit, stored and dispatched entry record
`include "rs_macros.svh"

package rs_entry_pkg;

    // Tag view keeps the waited-on tag in the low bits
    typedef struct packed {
        logic [`RS_VALUE_BITS-`RS_TAG_BITS-1:0] upper;  // Zero while waiting
        logic [`RS_TAG_BITS-1:0]                tag;    // Producer tag
    } operand_tag_t;

    // One word, decoded as a tag until ready and as a value after
    typedef union packed {
        operand_tag_t             tag_view;
        logic [`RS_VALUE_BITS-1:0] value;
    } operand_u;

    typedef struct packed {
        logic     ready;  // Set once the value is held
        operand_u data;
    } operand_t;

    // Whole instruction record, used for dispatch and for storage
    typedef struct packed {
        logic                    valid;      // Slot strobe on dispatch, occupancy when stored
        rs_issue_pkg::fu_type_e  fu_type;    // Target unit type
        logic [`RS_OP_BITS-1:0]  op;         // Operation code
        operand_t                op1;
        operand_t                op2;
        logic [`RS_TAG_BITS-1:0] dest_tag;   // Destination physical register
        logic [`RS_ROB_BITS-1:0] rob_entry;  // ROB entry of the instruction
    } station_t;

endpackage

/* src/rs_priority_pick.sv */
// Priority picker module: grant k marks the k-th lowest set request bit
`timescale 1ns/1ps

module rs_priority_pick #(
    parameter int REQ_WIDTH = 8,  // Request vector width
    parameter int GNT_COUNT = 2   // Number of ranked grants
) (
    input  logic [REQ_WIDTH-1:0]                req_i,
    output logic [GNT_COUNT-1:0][REQ_WIDTH-1:0] gnt_o
);

    logic [REQ_WIDTH-1:0] remaining;  // Requests not yet granted

    always_comb begin
        remaining = req_i;
        for (int k = 0; k < GNT_COUNT; k++) begin
            gnt_o[k]  = remaining & (~remaining + 1'b1);  // Isolate lowest set bit
            remaining = remaining & ~gnt_o[k];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // Grants one-hot or zero and disjoint across ranks
    always_comb begin : chk_grants
        logic [REQ_WIDTH-1:0] seen;
        seen = '0;
        for (int k = 0; k < GNT_COUNT; k++) begin
            assert ($onehot0(gnt_o[k]))
                else $error("Grant %0d is not one-hot", k);
            assert ((seen & gnt_o[k]) == '0)
                else $error("Grant %0d overlaps a lower rank", k);
            seen = seen | gnt_o[k];
        end
    end

endmodule

/* src/rs_alloc.sv */
// Free entry allocation module: lowest free entries per dispatch slot and the full flag
`timescale 1ns/1ps
`include "rs_macros.svh"

module rs_alloc (
    input  logic                                           clock_i,
    input  logic                                           reset_i,
    input  logic [`RS_ENTRIES-1:0]                         entry_valid_i,  // Occupied entries
    output logic [`RS_DISPATCH_WIDTH-1:0][`RS_ENTRIES-1:0] slot_gnt_o,     // Entry per slot
    output logic                                           rs_full_o
);

    logic [`RS_ENTRIES-1:0] free_list;  // Entries holding nothing

    assign free_list = ~entry_valid_i;

    // Slot k takes the k-th lowest free entry
    rs_priority_pick #(
        .REQ_WIDTH (`RS_ENTRIES),
        .GNT_COUNT (`RS_DISPATCH_WIDTH)
    ) u_free_pick (
        .req_i (free_list),
        .gnt_o (slot_gnt_o)
    );

    // Last slot without an entry means fewer free entries than slots
    assign rs_full_o = ~|slot_gnt_o[`RS_DISPATCH_WIDTH-1];

    // Queue comes out of reset empty
    a_empty_after_reset: assert property (@(posedge clock_i) reset_i |=> !rs_full_o)
        else $error("Queue full right after reset");

endmodule

/* src/rs_issue_select.sv */
// Issue select module: per-type ready detection, ranked pairing with free units, issue packets
`timescale 1ns/1ps
`include "rs_macros.svh"

module rs_issue_select (
    input  logic                                            clock_i,
    input  logic                                            reset_i,
    input  rs_entry_pkg::station_t [`RS_ENTRIES-1:0]        stations_i,
    input  logic [`RS_NUM_ALU-1:0]                          alu_free_i,
    input  logic [`RS_NUM_MUL-1:0]                          mul_free_i,
    output logic [`RS_NUM_ALU-1:0]                          alu_issue_valid_o,
    output rs_issue_pkg::issue_packet_t [`RS_NUM_ALU-1:0]   alu_issue_o,
    output logic [`RS_NUM_MUL-1:0]                          mul_issue_valid_o,
    output rs_issue_pkg::issue_packet_t [`RS_NUM_MUL-1:0]   mul_issue_o,
    output logic [`RS_ENTRIES-1:0]                          issue_clear_o  // Entries leaving
);

    logic [`RS_ENTRIES-1:0]                    alu_ready;
    logic [`RS_ENTRIES-1:0]                    mul_ready;
    logic [`RS_NUM_ALU-1:0][`RS_ENTRIES-1:0]   alu_entry_gnt;  // Ranked ready ALU entries
    logic [`RS_NUM_ALU-1:0][`RS_NUM_ALU-1:0]   alu_unit_gnt;   // Ranked free ALUs
    logic [`RS_NUM_MUL-1:0][`RS_ENTRIES-1:0]   mul_entry_gnt;
    logic [`RS_NUM_MUL-1:0][`RS_NUM_MUL-1:0]   mul_unit_gnt;

    // Valid, of the given type, both operands held
    function automatic logic is_ready(input rs_entry_pkg::station_t st,
                                      input rs_issue_pkg::fu_type_e ty);
        return st.valid && (st.fu_type == ty) && st.op1.ready && st.op2.ready;
    endfunction

    // Packet from the one-hot selected entry, operands read through the value view
    function automatic rs_issue_pkg::issue_packet_t build_packet(
        input rs_entry_pkg::station_t [`RS_ENTRIES-1:0] st,
        input logic [`RS_ENTRIES-1:0]                   sel
    );
        rs_issue_pkg::issue_packet_t pkt;
        pkt = '0;
        for (int e = 0; e < `RS_ENTRIES; e++) begin
            if (sel[e]) begin
                pkt.op        = st[e].op;
                pkt.value1    = st[e].op1.data.value;
                pkt.value2    = st[e].op2.data.value;
                pkt.dest_tag  = st[e].dest_tag;
                pkt.rob_entry = st[e].rob_entry;
            end
        end
        return pkt;
    endfunction

    always_comb begin
        for (int e = 0; e < `RS_ENTRIES; e++) begin
            alu_ready[e] = is_ready(stations_i[e], rs_issue_pkg::FU_ALU);
            mul_ready[e] = is_ready(stations_i[e], rs_issue_pkg::FU_MUL);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Ranked pickers, one over entries and one over units per type
    ////////////////////////////////////////////////////////////////////////////
    rs_priority_pick #(.REQ_WIDTH(`RS_ENTRIES), .GNT_COUNT(`RS_NUM_ALU)) u_alu_entry_pick (
        .req_i (alu_ready),
        .gnt_o (alu_entry_gnt)
    );

    rs_priority_pick #(.REQ_WIDTH(`RS_NUM_ALU), .GNT_COUNT(`RS_NUM_ALU)) u_alu_unit_pick (
        .req_i (alu_free_i),
        .gnt_o (alu_unit_gnt)
    );

    rs_priority_pick #(.REQ_WIDTH(`RS_ENTRIES), .GNT_COUNT(`RS_NUM_MUL)) u_mul_entry_pick (
        .req_i (mul_ready),
        .gnt_o (mul_entry_gnt)
    );

    rs_priority_pick #(.REQ_WIDTH(`RS_NUM_MUL), .GNT_COUNT(`RS_NUM_MUL)) u_mul_unit_pick (
        .req_i (mul_free_i),
        .gnt_o (mul_unit_gnt)
    );

    // Rank k entry goes to rank k unit, only when both exist
    always_comb begin
        alu_issue_valid_o = '0;
        alu_issue_o       = '0;
        mul_issue_valid_o = '0;
        mul_issue_o       = '0;
        issue_clear_o     = '0;
        for (int k = 0; k < `RS_NUM_ALU; k++) begin
            for (int u = 0; u < `RS_NUM_ALU; u++) begin
                if (alu_unit_gnt[k][u] && |alu_entry_gnt[k]) begin
                    alu_issue_valid_o[u] = 1'b1;
                    alu_issue_o[u]       = build_packet(stations_i, alu_entry_gnt[k]);
                    issue_clear_o        = issue_clear_o | alu_entry_gnt[k];
                end
            end
        end
        for (int k = 0; k < `RS_NUM_MUL; k++) begin
            for (int u = 0; u < `RS_NUM_MUL; u++) begin
                if (mul_unit_gnt[k][u] && |mul_entry_gnt[k]) begin
                    mul_issue_valid_o[u] = 1'b1;
                    mul_issue_o[u]       = build_packet(stations_i, mul_entry_gnt[k]);
                    issue_clear_o        = issue_clear_o | mul_entry_gnt[k];
                end
            end
        end
    end

    // Busy units never see a packet
    a_alu_busy: assert property (@(posedge clock_i) disable iff (reset_i)
        (alu_issue_valid_o & ~alu_free_i) == '0)
        else $error("Packet issued to a busy ALU");
    a_mul_busy: assert property (@(posedge clock_i) disable iff (reset_i)
        (mul_issue_valid_o & ~mul_free_i) == '0)
        else $error("Packet issued to a busy multiplier");

endmodule

/* src/rs_entry_array.sv */
// Entry array module: entry storage, dispatch write, result-bus wakeup, issue clear
`timescale 1ns/1ps
`include "rs_macros.svh"

module rs_entry_array (
    input  logic                                              clock_i,
    input  logic                                              reset_i,
    input  rs_entry_pkg::station_t [`RS_DISPATCH_WIDTH-1:0]   disp_i,
    input  logic [`RS_DISPATCH_WIDTH-1:0][`RS_ENTRIES-1:0]    slot_gnt_i,   // Entry per slot
    input  logic [`RS_ENTRIES-1:0]                            issue_clear_i,
    input  logic [`RS_CDB_WIDTH-1:0]                          cdb_valid_i,
    input  logic [`RS_CDB_WIDTH-1:0][`RS_TAG_BITS-1:0]        cdb_tag_i,
    input  logic [`RS_CDB_WIDTH-1:0][`RS_VALUE_BITS-1:0]      cdb_value_i,
    output rs_entry_pkg::station_t [`RS_ENTRIES-1:0]          stations_o,
    output logic [`RS_ENTRIES-1:0]                            entry_valid_o
);

    rs_entry_pkg::station_t [`RS_ENTRIES-1:0] stations_q;  // Stored entries
    rs_entry_pkg::station_t [`RS_ENTRIES-1:0] written;     // After dispatch writes
    rs_entry_pkg::station_t [`RS_ENTRIES-1:0] stations_n;  // Next state
    logic [`RS_ENTRIES-1:0]                   gnt_any;     // Entries taking a dispatch

    ////////////////////////////////////////////////////////////////////////////
    // Next state: dispatch, then wakeup, then clear
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        written = stations_q;
        gnt_any = '0;
        for (int s = 0; s < `RS_DISPATCH_WIDTH; s++) begin
            gnt_any = gnt_any | slot_gnt_i[s];
            for (int e = 0; e < `RS_ENTRIES; e++) begin
                if (slot_gnt_i[s][e] && disp_i[s].valid) begin
                    written[e] = disp_i[s];  // Idle slots leave the entry empty
                end
            end
        end

        // Wakeup sees same-cycle dispatches too
        stations_n = written;
        for (int e = 0; e < `RS_ENTRIES; e++) begin
            for (int l = 0; l < `RS_CDB_WIDTH; l++) begin
                if (cdb_valid_i[l] && written[e].valid) begin
                    if (!written[e].op1.ready &&
                        written[e].op1.data.tag_view.tag == cdb_tag_i[l]) begin
                        stations_n[e].op1.ready      = 1'b1;
                        stations_n[e].op1.data.value = cdb_value_i[l];  // Tag replaced by value
                    end
                    if (!written[e].op2.ready &&
                        written[e].op2.data.tag_view.tag == cdb_tag_i[l]) begin
                        stations_n[e].op2.ready      = 1'b1;
                        stations_n[e].op2.data.value = cdb_value_i[l];
                    end
                end
            end
        end

        // Issued entries free up at the next edge
        for (int e = 0; e < `RS_ENTRIES; e++) begin
            if (issue_clear_i[e]) begin
                stations_n[e].valid = 1'b0;
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            for (int e = 0; e < `RS_ENTRIES; e++) begin
                stations_q[e].valid <= 1'b0;  // Queue starts empty
            end
        end else begin
            stations_q <= stations_n;
        end
    end

    assign stations_o = stations_q;

    always_comb begin
        for (int e = 0; e < `RS_ENTRIES; e++) begin
            entry_valid_o[e] = stations_q[e].valid;
        end
    end

    // Allocation targets empty entries, issue targets full ones
    a_gnt_vs_clear: assert property (@(posedge clock_i) disable iff (reset_i)
        (gnt_any & issue_clear_i) == '0)
        else $error("Entry granted and cleared in the same cycle");

endmodule

/* src/rs_top.sv */
// Issue queue top module: allocator, issue selector and entry array
`timescale 1ns/1ps
`include "rs_macros.svh"

module rs_top (
    input  logic                                            clock_i,
    input  logic                                            reset_i,
    input  rs_entry_pkg::station_t [`RS_DISPATCH_WIDTH-1:0] disp_i,       // Valid field is the strobe
    input  logic [`RS_CDB_WIDTH-1:0]                        cdb_valid_i,
    input  logic [`RS_CDB_WIDTH-1:0][`RS_TAG_BITS-1:0]      cdb_tag_i,
    input  logic [`RS_CDB_WIDTH-1:0][`RS_VALUE_BITS-1:0]    cdb_value_i,
    input  logic [`RS_NUM_ALU-1:0]                          alu_free_i,
    input  logic [`RS_NUM_MUL-1:0]                          mul_free_i,
    output logic                                            rs_full_o,
    output logic [`RS_NUM_ALU-1:0]                          alu_issue_valid_o,
    output rs_issue_pkg::issue_packet_t [`RS_NUM_ALU-1:0]   alu_issue_o,
    output logic [`RS_NUM_MUL-1:0]                          mul_issue_valid_o,
    output rs_issue_pkg::issue_packet_t [`RS_NUM_MUL-1:0]   mul_issue_o
);

    logic [`RS_DISPATCH_WIDTH-1:0][`RS_ENTRIES-1:0] slot_gnt;
    logic [`RS_ENTRIES-1:0]                         issue_clear;
    logic [`RS_ENTRIES-1:0]                         entry_valid;
    rs_entry_pkg::station_t [`RS_ENTRIES-1:0]       stations;

    rs_alloc u_alloc (
        .clock_i       (clock_i),
        .reset_i       (reset_i),
        .entry_valid_i (entry_valid),
        .slot_gnt_o    (slot_gnt),
        .rs_full_o     (rs_full_o)
    );

    rs_issue_select u_select (
        .clock_i           (clock_i),
        .reset_i           (reset_i),
        .stations_i        (stations),
        .alu_free_i        (alu_free_i),
        .mul_free_i        (mul_free_i),
        .alu_issue_valid_o (alu_issue_valid_o),
        .alu_issue_o       (alu_issue_o),
        .mul_issue_valid_o (mul_issue_valid_o),
        .mul_issue_o       (mul_issue_o),
        .issue_clear_o     (issue_clear)
    );

    rs_entry_array u_array (
        .clock_i       (clock_i),
        .reset_i       (reset_i),
        .disp_i        (disp_i),
        .slot_gnt_i    (slot_gnt),
        .issue_clear_i (issue_clear),
        .cdb_valid_i   (cdb_valid_i),
        .cdb_tag_i     (cdb_tag_i),
        .cdb_value_i   (cdb_value_i),
        .stations_o    (stations),
        .entry_valid_o (entry_valid)
    );

endmodule

/* tb/rs_tb.sv */
// Issue queue testbench: clock, LFSR, station builders, compare and wait tasks, directed tests
`timescale 1ns/1ps
`include "rs_macros.svh"

module rs_tb;

    logic                                            clock;
    logic                                            reset;
    rs_entry_pkg::station_t [`RS_DISPATCH_WIDTH-1:0] disp;
    logic [`RS_CDB_WIDTH-1:0]                        cdb_valid;
    logic [`RS_CDB_WIDTH-1:0][`RS_TAG_BITS-1:0]      cdb_tag;
    logic [`RS_CDB_WIDTH-1:0][`RS_VALUE_BITS-1:0]    cdb_value;
    logic [`RS_NUM_ALU-1:0]                          alu_free;
    logic [`RS_NUM_MUL-1:0]                          mul_free;
    logic                                            rs_full;
    logic [`RS_NUM_ALU-1:0]                          alu_issue_valid;
    rs_issue_pkg::issue_packet_t [`RS_NUM_ALU-1:0]   alu_issue;
    logic [`RS_NUM_MUL-1:0]                          mul_issue_valid;
    rs_issue_pkg::issue_packet_t [`RS_NUM_MUL-1:0]   mul_issue;

    int          mismatch_count = 0;
    int          timeout_count  = 0;
    logic [31:0] lfsr_state     = 32'h718a0212;  // Operand value source

    initial clock = 1'b0;
    always #4 clock = ~clock;  // 8 ns period

    rs_top uut (
        .clock_i           (clock),
        .reset_i           (reset),
        .disp_i            (disp),
        .cdb_valid_i       (cdb_valid),
        .cdb_tag_i         (cdb_tag),
        .cdb_value_i       (cdb_value),
        .alu_free_i        (alu_free),
        .mul_free_i        (mul_free),
        .rs_full_o         (rs_full),
        .alu_issue_valid_o (alu_issue_valid),
        .alu_issue_o       (alu_issue),
        .mul_issue_valid_o (mul_issue_valid),
        .mul_issue_o       (mul_issue)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] random_value();
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < 32; b++) begin
            lfsr_state = lfsr_next(lfsr_state);  // One step per bit
            v          = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic rs_entry_pkg::operand_t ready_operand(input logic [31:0] value);
        rs_entry_pkg::operand_t o;
        o.ready      = 1'b1;
        o.data.value = value;
        return o;
    endfunction

    // Operand still waiting on a producer tag
    function automatic rs_entry_pkg::operand_t waiting_operand(input logic [5:0] tag);
        rs_entry_pkg::operand_t o;
        o.ready               = 1'b0;
        o.data.tag_view.upper = '0;
        o.data.tag_view.tag   = tag;
        return o;
    endfunction

    function automatic rs_entry_pkg::station_t make_station(
        input rs_issue_pkg::fu_type_e ty, input logic [3:0] op,
        input rs_entry_pkg::operand_t a, input rs_entry_pkg::operand_t b,
        input logic [5:0] dest, input logic [4:0] rob);
        rs_entry_pkg::station_t st;
        st.valid     = 1'b1;
        st.fu_type   = ty;
        st.op        = op;
        st.op1       = a;
        st.op2       = b;
        st.dest_tag  = dest;
        st.rob_entry = rob;
        return st;
    endfunction

    // Filler for the full flag test, ready ALU with random values
    function automatic rs_entry_pkg::station_t filler_station(input logic [4:0] rob);
        return make_station(rs_issue_pkg::FU_ALU, 4'h1, ready_operand(random_value()),
                            ready_operand(random_value()), {1'b1, rob}, rob);
    endfunction

    // Packet a unit should see: operation fields from the record, values known to the test
    function automatic rs_issue_pkg::issue_packet_t expected_packet(
        input rs_entry_pkg::station_t st, input logic [31:0] v1, input logic [31:0] v2);
        rs_issue_pkg::issue_packet_t p;
        p.op        = st.op;
        p.value1    = v1;
        p.value2    = v2;
        p.dest_tag  = st.dest_tag;
        p.rob_entry = st.rob_entry;
        return p;
    endfunction

    // Inputs change right after the rising edge, captured at the next one
    task automatic drive_dispatch(input rs_entry_pkg::station_t s0,
                                  input rs_entry_pkg::station_t s1);
        @(posedge clock);
        disp[0] <= s0;
        disp[1] <= s1;
        @(posedge clock);
        disp <= '0;
    endtask

    // One result lane for one cycle, with an optional dispatch in the same cycle
    task automatic drive_broadcast(input int lane, input logic [5:0] tag,
                                   input logic [31:0] value, input rs_entry_pkg::station_t st);
        @(posedge clock);
        disp[0]         <= st;
        cdb_valid[lane] <= 1'b1;
        cdb_tag[lane]   <= tag;
        cdb_value[lane] <= value;
        @(posedge clock);
        disp      <= '0;
        cdb_valid <= '0;
    endtask

    task automatic set_units(input logic [`RS_NUM_ALU-1:0] alu, input logic [`RS_NUM_MUL-1:0] mul);
        @(posedge clock);
        alu_free <= alu;
        mul_free <= mul;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Compare and wait tasks, sampling at the falling edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_packet(input rs_issue_pkg::issue_packet_t actual,
                                input rs_issue_pkg::issue_packet_t expected, input string what);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch at %0t ns: %s, expected %h, got %h", $time, what, expected, actual);
        end
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch at %0t ns: %s, expected %b, got %b", $time, what, expected, actual);
        end
    endtask

    function automatic logic issue_seen(input rs_issue_pkg::fu_type_e ty, input int unit);
        if (ty == rs_issue_pkg::FU_ALU) begin
            return alu_issue_valid[unit];
        end
        return mul_issue_valid[unit];
    endfunction

    // Cycles counts falling edges after the first one
    task automatic wait_issue(input rs_issue_pkg::fu_type_e ty, input int unit,
                              input int limit, output int cycles);
        cycles = 0;
        @(negedge clock);
        while (!issue_seen(ty, unit) && cycles < limit) begin
            @(negedge clock);
            cycles++;
        end
        if (!issue_seen(ty, unit)) begin
            timeout_count++;
            $display("Timeout at %0t ns: no packet reached unit %0d", $time, unit);
        end
    endtask

    task automatic wait_full(input logic level, input int limit, output int cycles);
        cycles = 0;
        @(negedge clock);
        while (rs_full !== level && cycles < limit) begin
            @(negedge clock);
            cycles++;
        end
        if (rs_full !== level) begin
            timeout_count++;
            $display("Timeout at %0t ns: full flag never reached %b", $time, level);
        end
    endtask

    // All units free, so no issue means the queue is empty
    task automatic wait_drained(input int limit);
        int cycles;
        cycles = 0;
        @(negedge clock);
        while ((|alu_issue_valid || |mul_issue_valid) && cycles < limit) begin
            @(negedge clock);
            cycles++;
        end
        if (|alu_issue_valid || |mul_issue_valid) begin
            timeout_count++;
            $display("Timeout at %0t ns: queue did not drain", $time);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_ready_alu();
        rs_entry_pkg::station_t st;
        logic [31:0] a;
        logic [31:0] b;
        int          lat;
        a  = random_value();
        b  = random_value();
        st = make_station(rs_issue_pkg::FU_ALU, 4'h3, ready_operand(a), ready_operand(b),
                          6'h11, 5'd3);
        drive_dispatch(st, '0);
        wait_issue(rs_issue_pkg::FU_ALU, 0, 4, lat);
        check_bit(lat == 0, 1'b1, "ready ALU issues the cycle after dispatch");
        check_packet(alu_issue[0], expected_packet(st, a, b), "ready ALU packet");
        check_bit(alu_issue_valid[1], 1'b0, "second ALU idle");
        @(negedge clock);
        check_bit(alu_issue_valid[0], 1'b0, "ALU valid low once the entry left");
    endtask

    task automatic test_wakeup();
        rs_entry_pkg::station_t st;
        logic [31:0] v;
        logic [31:0] b;
        int          lat;
        v  = random_value();
        b  = random_value();
        st = make_station(rs_issue_pkg::FU_ALU, 4'h5, waiting_operand(6'h2a), ready_operand(b),
                          6'h12, 5'd4);
        drive_dispatch(st, '0);
        @(negedge clock);
        check_bit(alu_issue_valid[0], 1'b0, "waiting entry held back");
        drive_broadcast(0, 6'h2a, v, '0);
        wait_issue(rs_issue_pkg::FU_ALU, 0, 4, lat);
        check_bit(lat == 0, 1'b1, "woken entry issues the cycle after the broadcast");
        check_packet(alu_issue[0], expected_packet(st, v, b), "woken entry packet");
        @(negedge clock);
        check_bit(alu_issue_valid[0], 1'b0, "woken entry gone");

        // Tag arrives on lane 1 in the dispatch cycle itself
        b  = random_value();
        v  = random_value();
        st = make_station(rs_issue_pkg::FU_ALU, 4'h6, ready_operand(b), waiting_operand(6'h15),
                          6'h13, 5'd5);
        drive_broadcast(1, 6'h15, v, st);
        wait_issue(rs_issue_pkg::FU_ALU, 0, 4, lat);
        check_bit(lat == 0, 1'b1, "same-cycle wakeup issues the next cycle");
        check_packet(alu_issue[0], expected_packet(st, b, v), "same-cycle wakeup packet");
        @(negedge clock);
        check_bit(alu_issue_valid[0], 1'b0, "same-cycle entry gone");
    endtask

    task automatic test_back_pressure();
        rs_entry_pkg::station_t st;
        logic [31:0] a;
        logic [31:0] b;
        int          lat;
        a  = random_value();
        b  = random_value();
        st = make_station(rs_issue_pkg::FU_MUL, 4'h7, ready_operand(a), ready_operand(b),
                          6'h20, 5'd9);
        set_units('1, 1'b0);
        drive_dispatch(st, '0);
        for (int c = 0; c < 4; c++) begin
            @(negedge clock);
            check_bit(mul_issue_valid[0], 1'b0, "multiply held while the unit is busy");
            check_bit(|alu_issue_valid, 1'b0, "multiply never goes to an ALU");
        end
        set_units('1, 1'b1);
        wait_issue(rs_issue_pkg::FU_MUL, 0, 4, lat);
        check_bit(lat == 0, 1'b1, "held multiply issues once the unit frees");
        check_packet(mul_issue[0], expected_packet(st, a, b), "held multiply packet");
        @(negedge clock);
        check_bit(mul_issue_valid[0], 1'b0, "multiply entry gone");
    endtask

    task automatic test_pairing();
        rs_entry_pkg::station_t sa;
        rs_entry_pkg::station_t sb;
        rs_entry_pkg::station_t sc;
        int                     lat;
        sa = filler_station(5'd10);
        sb = filler_station(5'd11);
        sc = filler_station(5'd12);
        @(posedge clock);
        disp[0] <= sa;
        disp[1] <= sb;
        @(posedge clock);
        disp[0] <= sc;  // Third one a cycle later
        disp[1] <= '0;
        wait_issue(rs_issue_pkg::FU_ALU, 1, 4, lat);
        check_bit(lat == 0, 1'b1, "pair issues the cycle after dispatch");
        check_bit(alu_issue_valid[0], 1'b1, "ALU 0 takes the first entry");
        check_packet(alu_issue[0], expected_packet(sa, sa.op1.data.value, sa.op2.data.value),
                     "first dispatched to ALU 0");
        check_packet(alu_issue[1], expected_packet(sb, sb.op1.data.value, sb.op2.data.value),
                     "second dispatched to ALU 1");
        @(posedge clock);
        disp <= '0;
        wait_issue(rs_issue_pkg::FU_ALU, 0, 4, lat);
        check_bit(lat == 0, 1'b1, "third issues the cycle after the pair");
        check_bit(alu_issue_valid[1], 1'b0, "ALU 1 idle with one ready entry");
        check_packet(alu_issue[0], expected_packet(sc, sc.op1.data.value, sc.op2.data.value),
                     "third dispatched to ALU 0");
        @(negedge clock);
        check_bit(alu_issue_valid[0], 1'b0, "pairing entries gone");
    endtask

    task automatic test_full_flag();
        int count;
        int lat;
        set_units('0, 1'b0);
        drive_dispatch(filler_station(5'd16), '0);  // Odd start, so pairs hit 7
        count = 1;
        @(negedge clock);
        while (!rs_full && count < `RS_ENTRIES) begin
            drive_dispatch(filler_station(5'(16 + count)), filler_station(5'(17 + count)));
            count += 2;
            @(negedge clock);
        end
        check_bit(rs_full, 1'b1, "full flag set");
        check_bit(count == `RS_ENTRIES - 1, 1'b1, "full flag rises at 7 valid entries");
        set_units(`RS_NUM_ALU'(1), 1'b0);
        wait_full(1'b0, 4, lat);
        check_bit(lat == 1, 1'b1, "full flag falls after the issued entry clears");
        set_units('1, '1);
        wait_drained(16);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        reset     = 1'b1;
        disp      = '0;
        cdb_valid = '0;
        cdb_tag   = '0;
        cdb_value = '0;
        alu_free  = '1;
        mul_free  = '1;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_bit(rs_full, 1'b0, "full flag low after reset");
        check_bit(|alu_issue_valid, 1'b0, "no ALU issue after reset");
        check_bit(|mul_issue_valid, 1'b0, "no multiply issue after reset");

        test_ready_alu();
        test_wakeup();
        test_back_pressure();
        test_pairing();
        test_full_flag();

        $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+include
src/rs_issue_pkg.sv
src/rs_entry_pkg.sv
src/rs_priority_pick.sv
src/rs_alloc.sv
src/rs_issue_select.sv
src/rs_entry_array.sv
src/rs_top.sv
tb/rs_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the issue queue testbench with Verilator, runs it and scans the log
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module rs_tb -o rs_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rs_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0
